// ==== verilog/ahb_macros.svh ====
`ifndef AHB_MACROS_SVH
`define AHB_MACROS_SVH

// memory sizes in 32-bit words
`define AHB_ROM_WORDS   16384           // 64 KB program store
`define AHB_RAM_WORDS   1024            // 4 KB scratch, aliased in its window

// width of the led and switch ports on the gpio block
`define AHB_GPIO_WIDTH  8

// slave base addresses, each window spans 64 KB
`define AHB_ROM_BASE    32'h0000_0000   // program rom
`define AHB_RAM_BASE    32'h2000_0000   // data ram
`define AHB_GPIO_BASE   32'h2020_0000   // leds and switches

`endif

// ==== verilog/ahb_pkg.sv ====
`default_nettype none

package ahb_pkg;

    // one bus word, used for haddr, hwdata and hrdata alike
    typedef logic [31:0] word_t;

    // owner of the current data phase
    typedef enum logic [1:0] {
        SLV_NONE = 2'd0,    // idle, busy or unmapped
        SLV_ROM  = 2'd1,    // program rom window
        SLV_RAM  = 2'd2,    // data ram window
        SLV_GPIO = 2'd3     // gpio window
    } slave_e;

endpackage

`default_nettype wire

// ==== verilog/ahb_slave_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface ahb_slave_if import ahb_pkg::*; ();

    logic  sel;     // slave owns this data phase
    word_t addr;    // registered address-phase haddr
    logic  write;   // registered hwrite
    word_t wdata;   // hwdata of the data phase
    word_t rdata;   // read data back from the slave

    // decoder side
    modport fabric (
        output sel,
        output addr,
        output write,
        output wdata,
        input  rdata
    );

    // memory or peripheral side
    modport slave (
        input  sel,
        input  addr,
        input  write,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== verilog/ahb_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ahb_macros.svh"

module ahb_decoder import ahb_pkg::*; (
    input  logic        HCLK,
    input  logic        rst,
    input  word_t       haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  word_t       hwdata,
    output word_t       hrdata,
    ahb_slave_if.fabric rom_bus,
    ahb_slave_if.fabric ram_bus,
    ahb_slave_if.fabric gpio_bus
);

    localparam word_t ROM_BASE  = `AHB_ROM_BASE;
    localparam word_t RAM_BASE  = `AHB_RAM_BASE;
    localparam word_t GPIO_BASE = `AHB_GPIO_BASE;

    slave_e dec_sel;    // decode of the current address phase
    slave_e dp_sel;     // slave owning the data phase
    word_t  dp_addr;    // captured haddr
    logic   dp_write;   // captured hwrite

    // htrans[1] marks NONSEQ/SEQ, idle and busy select nothing
    always_comb begin
        dec_sel = SLV_NONE;
        if (htrans[1]) begin
            if (haddr[31:16] == ROM_BASE[31:16]) begin
                dec_sel = SLV_ROM;
            end else if (haddr[31:16] == RAM_BASE[31:16]) begin
                dec_sel = SLV_RAM;
            end else if (haddr[31:16] == GPIO_BASE[31:16]) begin
                dec_sel = SLV_GPIO;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            dp_sel <= SLV_NONE;     // no data phase after reset
        end else begin
            dp_sel <= dec_sel;      // address phase -> data phase
        end
    end

    // payload only, meaningless while dp_sel is SLV_NONE
    always_ff @(posedge HCLK) begin
        if (htrans[1]) begin
            dp_addr  <= haddr;
            dp_write <= hwrite;
        end
    end

    assign rom_bus.sel    = (dp_sel == SLV_ROM);
    assign rom_bus.addr   = dp_addr;
    assign rom_bus.write  = dp_write;
    assign rom_bus.wdata  = hwdata;     // data phase pass-through

    assign ram_bus.sel    = (dp_sel == SLV_RAM);
    assign ram_bus.addr   = dp_addr;
    assign ram_bus.write  = dp_write;
    assign ram_bus.wdata  = hwdata;

    assign gpio_bus.sel   = (dp_sel == SLV_GPIO);
    assign gpio_bus.addr  = dp_addr;
    assign gpio_bus.write = dp_write;
    assign gpio_bus.wdata = hwdata;

    // read mux, combinational in the data phase
    always_comb begin
        unique case (dp_sel)
            SLV_ROM:  hrdata = rom_bus.rdata;
            SLV_RAM:  hrdata = ram_bus.rdata;
            SLV_GPIO: hrdata = gpio_bus.rdata;
            default:  hrdata = '0;          // unmapped reads zero
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ahb_rom.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ahb_macros.svh"

module ahb_rom import ahb_pkg::*; (
    ahb_slave_if.slave bus
);

    localparam int IDX_MSB = $clog2(`AHB_ROM_WORDS) + 1;   // haddr[15:2]

    word_t rom [`AHB_ROM_WORDS];    // 16K x 32

    initial begin
        for (int i = 0; i < `AHB_ROM_WORDS; i++) begin
            rom[i] = '0;                // unused space reads zero
        end
        // build the gpio address 0x2020_0000 in r0
        rom[0]  = 32'he3a00002;         // r0 = 2
        rom[1]  = 32'he1a00400;         // r0 <<= 8
        rom[2]  = 32'he2800002;         // r0 += 2
        rom[3]  = 32'he1a00a00;         // r0 <<= 20
        // walk one lit led across three positions
        rom[4]  = 32'he3a01001;         // r1 = 1
        rom[5]  = 32'he5801000;         // leds = r1
        rom[6]  = 32'he1a01081;         // r1 <<= 1
        rom[7]  = 32'he5801000;         // leds = r1
        rom[8]  = 32'he1a01081;         // r1 <<= 1
        rom[9]  = 32'he5801000;         // leds = r1
        rom[10] = 32'he3a01001;         // r1 = 1 again
        rom[11] = 32'heafffff8;         // back to the first store
        for (int i = 12; i < 24; i++) begin
            rom[i] = 32'heafffff7;      // branch padding, 12..23
        end
    end

    // combinational read of the registered address, writes dropped
    assign bus.rdata = bus.sel ? rom[bus.addr[IDX_MSB:2]] : '0;

endmodule

`default_nettype wire

// ==== verilog/ahb_ram.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ahb_macros.svh"

module ahb_ram import ahb_pkg::*; (
    input  logic       HCLK,
    ahb_slave_if.slave bus
);

    localparam int IDX_MSB = $clog2(`AHB_RAM_WORDS) + 1;   // haddr[11:2]

    word_t              mem [`AHB_RAM_WORDS];   // contents survive reset
    logic [IDX_MSB-2:0] idx;                    // word index
    logic               wr_en;                  // write data phase

    assign idx   = bus.addr[IDX_MSB:2];
    assign wr_en = bus.sel && bus.write;

    // write lands at the edge closing the data phase
    always_ff @(posedge HCLK) begin
        if (wr_en) begin
            mem[idx] <= bus.wdata;
        end
    end

    // combinational read, next data phase sees a fresh write
    assign bus.rdata = bus.sel ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== verilog/ahb_gpio.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ahb_macros.svh"

module ahb_gpio import ahb_pkg::*; (
    input  logic                       HCLK,
    input  logic                       rst,
    ahb_slave_if.slave                 bus,
    input  logic [`AHB_GPIO_WIDTH-1:0] switches,
    output logic [`AHB_GPIO_WIDTH-1:0] leds
);

    logic [`AHB_GPIO_WIDTH-1:0] led_q;  // led output register
    logic                       in_map; // offset 0x0 or 0x4
    logic                       led_wr; // write hits offset 0x0

    // only the first two words of the window hold registers
    assign in_map = (bus.addr[15:3] == '0);
    assign led_wr = bus.sel && bus.write && in_map && !bus.addr[2];

    always_ff @(posedge HCLK) begin
        if (rst) begin
            led_q <= '0;                            // leds dark after reset
        end else if (led_wr) begin
            led_q <= bus.wdata[`AHB_GPIO_WIDTH-1:0];
        end
    end

    assign leds = led_q;

    // bit 2 picks switches over leds, zero elsewhere
    always_comb begin
        bus.rdata = '0;
        if (bus.sel && in_map) begin
            if (bus.addr[2]) begin
                bus.rdata = word_t'(switches);     // zero-extended
            end else begin
                bus.rdata = word_t'(led_q);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ahb_lite.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ahb_macros.svh"

module ahb_lite (
    input  logic                       HCLK,
    input  logic                       rst,
    input  logic [31:0]                haddr,
    input  logic [1:0]                 htrans,
    input  logic                       hwrite,
    input  logic [31:0]                hwdata,
    output logic [31:0]                hrdata,
    input  logic [`AHB_GPIO_WIDTH-1:0] switches,
    output logic [`AHB_GPIO_WIDTH-1:0] leds
);

    // one bundle per slave
    ahb_slave_if rom_bus ();
    ahb_slave_if ram_bus ();
    ahb_slave_if gpio_bus ();

    // address-phase capture and read mux
    ahb_decoder ahb_decoder_i (
        .HCLK     (HCLK),
        .rst      (rst),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .rom_bus  (rom_bus.fabric),
        .ram_bus  (ram_bus.fabric),
        .gpio_bus (gpio_bus.fabric)
    );

    // 0x0000_0000 program rom
    ahb_rom ahb_rom_i (
        .bus (rom_bus.slave)
    );

    // 0x2000_0000 data ram
    ahb_ram ahb_ram_i (
        .HCLK (HCLK),
        .bus  (ram_bus.slave)
    );

    // 0x2020_0000 leds and switches
    ahb_gpio ahb_gpio_i (
        .HCLK     (HCLK),
        .rst      (rst),
        .bus      (gpio_bus.slave),
        .switches (switches),
        .leds     (leds)
    );

endmodule

`default_nettype wire

// ==== test/ahb_lite_props.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ahb_macros.svh"

module ahb_lite_props import ahb_pkg::*; (
    input logic       HCLK,
    input logic       rst,
    input word_t      haddr,      // address phase of the master
    input logic [1:0] htrans,
    input logic       rom_sel,
    input logic       ram_sel,
    input logic       gpio_sel,
    input word_t      hrdata      // decoder read mux output
);

    localparam word_t ROM_BASE  = `AHB_ROM_BASE;
    localparam word_t RAM_BASE  = `AHB_RAM_BASE;
    localparam word_t GPIO_BASE = `AHB_GPIO_BASE;

    logic       any_sel;  // some slave owns the data phase
    logic [2:0] win_hit;  // rom, ram, gpio window of haddr

    assign any_sel = rom_sel || ram_sel || gpio_sel;
    assign win_hit = {haddr[31:16] == ROM_BASE[31:16],
                      haddr[31:16] == RAM_BASE[31:16],
                      haddr[31:16] == GPIO_BASE[31:16]};

    // a transfer selects only the slave whose window it hits
    one_slave: assert property (
        @(posedge HCLK) disable iff (rst)
        htrans[1] |=> ({rom_sel, ram_sel, gpio_sel} == $past(win_hit))
    ) else $error("data phase select does not match the address window");

    // idle and busy phases leave the next data phase empty
    idle_no_sel: assert property (
        @(posedge HCLK) disable iff (rst)
        !htrans[1] |=> !any_sel
    ) else $error("slave selected after an idle or busy address phase");

    // unmapped or empty data phase
    empty_reads_zero: assert property (
        @(posedge HCLK) disable iff (rst)
        !any_sel |-> (hrdata == 32'h0)
    ) else $error("read data not zero while no slave is selected");

endmodule

bind ahb_decoder ahb_lite_props ahb_lite_props_i (
    .HCLK     (HCLK),
    .rst      (rst),
    .haddr    (haddr),
    .htrans   (htrans),
    .rom_sel  (rom_bus.sel),
    .ram_sel  (ram_bus.sel),
    .gpio_sel (gpio_bus.sel),
    .hrdata   (hrdata)
);

`default_nettype wire

// ==== test/ahb_lite_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ahb_macros.svh"

module ahb_lite_tb import ahb_pkg::*; ();

    localparam word_t RAM_BASE  = `AHB_RAM_BASE;
    localparam word_t GPIO_BASE = `AHB_GPIO_BASE;
    localparam word_t ROM_BASE  = `AHB_ROM_BASE;

    // led program, rom words 0..11
    localparam word_t PROG [12] = '{
        32'he3a00002, 32'he1a00400, 32'he2800002, 32'he1a00a00,
        32'he3a01001, 32'he5801000, 32'he1a01081, 32'he5801000,
        32'he1a01081, 32'he5801000, 32'he3a01001, 32'heafffff8
    };

    logic        HCLK;
    logic        rst;
    word_t       haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    word_t       hwdata;
    word_t       hrdata;
    logic [7:0]  switches;
    logic [7:0]  leds;

    word_t       ram_model [1024];  // shadow of the data ram
    logic [7:0]  led_model;         // shadow of the led register
    logic        pend_valid;        // transfer waiting for its data phase
    logic        pend_write;
    word_t       pend_addr;
    word_t       pend_wdata;
    int          errors;
    int          checks;

    ahb_lite ahb_lite_i (
        .HCLK     (HCLK),
        .rst      (rst),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .switches (switches),
        .leds     (leds)
    );

    initial begin
        HCLK = 1'b0;
        forever #10 HCLK = ~HCLK;   // 20 ns period
    end

    // read value per the memory map
    function automatic word_t expected_read(input word_t addr);
        word_t v;
        v = 32'h0;                                      // unmapped reads zero
        if (addr[31:16] == ROM_BASE[31:16]) begin
            if (addr[15:2] < 14'd12) begin
                v = PROG[addr[5:2]];
            end else if (addr[15:2] < 14'd24) begin
                v = 32'heafffff7;                       // branch padding
            end
        end else if (addr[31:16] == RAM_BASE[31:16]) begin
            v = ram_model[addr[11:2]];                  // 4 KB aliased
        end else if (addr[31:16] == GPIO_BASE[31:16] && addr[15:3] == 13'h0) begin
            v = addr[2] ? {24'h0, switches} : {24'h0, led_model};
        end
        return v;
    endfunction

    // ram and led register take writes, rom and switches do not
    function automatic void apply_write(input word_t addr, input word_t data);
        if (addr[31:16] == RAM_BASE[31:16]) begin
            ram_model[addr[11:2]] = data;
        end else if (addr[31:16] == GPIO_BASE[31:16] && addr[15:3] == 13'h0 && !addr[2]) begin
            led_model = data[7:0];
        end
    endfunction

    function automatic word_t ram_addr(input logic [4:0] idx, input logic [3:0] alias_bits);
        return RAM_BASE | {16'h0, alias_bits, 5'd0, idx, 2'b00};
    endfunction

    // one clock: data phase of the pending transfer, address phase of the next
    task automatic bus_cycle(input logic [1:0] trans, input logic wr, input word_t addr,
                             input word_t data);
        word_t exp;
        @(negedge HCLK);
        led_check: assert (leds == led_model) else begin
            $display("error %0t: leds %h, expected %h", $time, leds, led_model);
            errors++;
        end
        if (pend_valid && !pend_write) begin
            exp = expected_read(pend_addr);     // model before this cycle's write
            checks++;
            read_check: assert (hrdata == exp) else begin
                $display("error %0t: read %h returned %h, expected %h",
                         $time, pend_addr, hrdata, exp);
                errors++;
            end
        end
        hwdata = 32'h0;
        if (pend_valid && pend_write) begin
            hwdata = pend_wdata;                // lands at the next rising edge
            apply_write(pend_addr, pend_wdata);
        end
        htrans     = trans;
        haddr      = addr;
        hwrite     = wr;
        pend_valid = trans[1];                  // only nonseq/seq transfer
        pend_write = wr;
        pend_addr  = addr;
        pend_wdata = data;
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        bus_cycle(2'b10, 1'b1, addr, data);
    endtask

    task automatic read_word(input word_t addr);
        bus_cycle(2'b10, 1'b0, addr, 32'h0);
    endtask

    task automatic idle_cycle();
        bus_cycle(2'b00, 1'b0, 32'h0, 32'h0);
    endtask

    // leds settle within a few cycles or the wait gives up
    task automatic wait_leds(input logic [7:0] value);
        int waited;
        waited = 0;
        while (leds != value && waited < 8) begin
            idle_cycle();
            waited++;
        end
        led_timeout: assert (leds == value) else begin
            $display("timed out waiting for leds to show %h", value);
            errors++;
        end
    endtask

    initial begin
        word_t      rnd;
        word_t      a;
        logic [13:0] ri;
        rnd        = $urandom(32'h4c1651f3);    // seeds the generator once
        rst        = 1'b1;
        haddr      = 32'h0;
        htrans     = 2'b00;
        hwrite     = 1'b0;
        hwdata     = 32'h0;
        switches   = 8'h00;
        led_model  = 8'h00;
        pend_valid = 1'b0;
        pend_write = 1'b0;
        pend_addr  = 32'h0;
        pend_wdata = 32'h0;
        errors     = 0;
        checks     = 0;
        repeat (2) @(posedge HCLK);
        @(negedge HCLK);
        rst = 1'b0;
        rst_leds: assert (leds == 8'h00) else begin
            $display("error %0t: leds %h after reset, expected 00", $time, leds);
            errors++;
        end

        // rom: program words, padding, empty space, dropped write
        for (int i = 0; i < 24; i++) begin
            read_word(ROM_BASE | {16'h0, i[13:0], 2'b00});
        end
        for (int i = 0; i < 16; i++) begin
            rnd = $urandom;
            ri  = rnd[13:0];
            if (ri < 14'd24) ri = ri | 14'h0100;    // keep above the program
            read_word({16'h0000, ri, 2'b00});
        end
        write_word(32'h0000_0014, 32'h1234_5678);
        read_word(32'h0000_0014);

        // ram: preload 32 words, then mixed traffic with aliasing
        for (int i = 0; i < 32; i++) begin
            write_word(ram_addr(i[4:0], 4'h0), $urandom);
        end
        for (int n = 0; n < 240; n++) begin
            rnd = $urandom;
            a   = ram_addr(rnd[4:0], rnd[15:12]);
            case (rnd[31:29])
                3'd0: bus_cycle(rnd[8] ? 2'b01 : 2'b00, rnd[9], a, 32'h0); // idle or busy
                3'd1: begin
                    write_word(a, $urandom);
                    read_word(a);                   // back to back after the write
                end
                3'd2, 3'd3: write_word(a, $urandom);
                default: read_word(a);
            endcase
        end

        // gpio
        idle_cycle();
        switches = 8'h5a;
        write_word(GPIO_BASE, 32'hffff_ff3c);       // upper bits dropped
        idle_cycle();
        wait_leds(8'h3c);
        read_word(GPIO_BASE);
        read_word(GPIO_BASE | 32'h4);
        write_word(GPIO_BASE | 32'h4, 32'h0000_00c3); // switches read only
        read_word(GPIO_BASE);
        write_word(GPIO_BASE | 32'h10, 32'h0000_0099);
        read_word(GPIO_BASE | 32'h10);
        switches = 8'ha7;
        read_word(GPIO_BASE | 32'h4);

        // unmapped space
        read_word(32'h4000_0000);
        write_word(32'h4000_0000, 32'hdead_beef);
        write_word(32'h2010_0000, 32'hcafe_f00d);   // gap between ram and gpio
        read_word(32'hffff_fffc);
        read_word(ram_addr(5'd0, 4'h0));
        read_word(GPIO_BASE);

        // replay of the rom program's led stores
        for (int pass = 0; pass < 2; pass++) begin
            for (int k = 0; k < 3; k++) begin
                write_word(GPIO_BASE, 32'h1 << k);
                idle_cycle();
                wait_leds(8'h01 << k);
            end
        end
        idle_cycle();
        idle_cycle();

        $display("%0d read checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/ahb_pkg.sv
verilog/ahb_slave_if.sv
verilog/ahb_decoder.sv
verilog/ahb_rom.sv
verilog/ahb_ram.sv
verilog/ahb_gpio.sv
verilog/ahb_lite.sv
test/ahb_lite_props.sv
test/ahb_lite_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ahb-lite testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module ahb_lite_tb \
    -f sources.f \
    -o ahb_lite_sim

status=0
./obj_dir/ahb_lite_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation stopped with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi

exit 0
